/* src.f */
+incdir+common
common/stripe_addr_pkg.sv
common/stripe_ctrl_pkg.sv
common/word_rd_if.sv
source/bank_ram.sv
stripe_reader/read_words.sv
stripe_reader/stripe_reader.sv
source/stripe_top.sv
sim/stripe_checker.sv
sim/stripe_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= stripe_tb
RTL_TOP    ?= stripe_top
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/stripe_tb.sv */
`timescale 1ns/1ps
`include "stripe_defines.svh"

module stripe_tb import stripe_addr_pkg::*; ();

  localparam int CLK_HALF = 20;
  localparam int RESET_CYCLES = 8;
  localparam int FILL_WORDS = `STRIPE_NUM_S * `STRIPE_BANK_DEPTH;
  localparam int MAX_ENTRIES = 16;
  localparam logic OP_FILL = 1'b0;
  localparam logic OP_READ = 1'b1;

  logic                            axi_clk;
  logic                            axi_resetn;
  word_addr_t                      rd_addr;
  logic [`STRIPE_ARLENW_WIDTH-1:0] rd_arlenw;
  logic                            rd_valid;
  logic                            rd_ready;
  rd_word_t                        rd_data;
  rd_resp_t                        rd_resp;
  logic                            rd_dvalid;
  logic                            rd_last;
  logic                            rd_dready;
  logic                            wr_en;
  word_addr_t                      wr_addr;
  rd_word_t                        wr_data;

  logic        report_req;
  logic        report_done;
  int          error_total;
  int          table_errors;
  logic [31:0] rng;

  // each stimulus entry holds operation, start word, arlenw, back-pressure, chain and final response
  logic     op_tab    [MAX_ENTRIES];
  int       addr_tab  [MAX_ENTRIES];
  int       len_tab   [MAX_ENTRIES];
  logic     bp_tab    [MAX_ENTRIES];
  logic     chain_tab [MAX_ENTRIES];
  rd_resp_t resp_tab  [MAX_ENTRIES];
  int       n_entries;

  stripe_top stripe_top_inst (
    .axi_clk   (axi_clk),
    .axi_resetn(axi_resetn),
    .rd_addr   (rd_addr),
    .rd_arlenw (rd_arlenw),
    .rd_valid  (rd_valid),
    .rd_ready  (rd_ready),
    .rd_data   (rd_data),
    .rd_resp   (rd_resp),
    .rd_dvalid (rd_dvalid),
    .rd_last   (rd_last),
    .rd_dready (rd_dready),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data)
  );

  stripe_checker stripe_checker_inst (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .rd_addr    (rd_addr),
    .rd_arlenw  (rd_arlenw),
    .rd_valid   (rd_valid),
    .rd_ready   (rd_ready),
    .rd_data    (rd_data),
    .rd_resp    (rd_resp),
    .rd_dvalid  (rd_dvalid),
    .rd_last    (rd_last),
    .rd_dready  (rd_dready),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .tb_errors  (table_errors),
    .report_req (report_req),
    .report_done(report_done),
    .error_total(error_total)
  );

  initial begin
    axi_clk = 1'b0;
    forever begin
      #CLK_HALF axi_clk = ~axi_clk;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic add_entry(input logic op, input int addr, input int len, input logic bp,
                           input logic chain, input rd_resp_t resp);
    op_tab[n_entries]    = op;
    addr_tab[n_entries]  = addr;
    len_tab[n_entries]   = len;
    bp_tab[n_entries]    = bp;
    chain_tab[n_entries] = chain;
    resp_tab[n_entries]  = resp;
    n_entries++;
  endtask

  task automatic build_table();
    n_entries = 0;
    add_entry(OP_FILL, 0, 0, 1'b0, 1'b0, OKAY);
    add_entry(OP_READ, 0, 7, 1'b0, 1'b0, OKAY);
    add_entry(OP_READ, 2, 1, 1'b0, 1'b0, OKAY);
    add_entry(OP_READ, 8, 3, 1'b0, 1'b0, OKAY);
    add_entry(OP_READ, 100, 31, 1'b0, 1'b0, OKAY);
    add_entry(OP_READ, 40, 15, 1'b1, 1'b0, OKAY);
    add_entry(OP_READ, 200, 31, 1'b1, 1'b0, OKAY);
    // the upper half of this one lies past the last bank offset
    add_entry(OP_READ, 504, 15, 1'b0, 1'b0, SLVERR);
    add_entry(OP_READ, 16, 5, 1'b0, 1'b1, OKAY);
    add_entry(OP_READ, 64, 9, 1'b1, 1'b1, OKAY);
    add_entry(OP_READ, 500, 19, 1'b1, 1'b0, SLVERR);
    add_entry(OP_READ, 300, 3, 1'b1, 1'b0, OKAY);
  endtask

  function automatic int max_arlenw();
    int m;
    m = 0;
    for (int i = 0; i < n_entries; i++) begin
      if (op_tab[i] == OP_READ && len_tab[i] > m) begin
        m = len_tab[i];
      end
    end
    return m;
  endfunction

  task automatic fill_banks();
    wr_en = 1'b1;
    for (int a = 0; a < FILL_WORDS; a++) begin
      wr_addr.flat = `STRIPE_ADDR_WIDTH'(a);
      wr_data      = rd_word_t'(a) ^ 16'h5a3c;
      @(negedge axi_clk);
    end
    wr_en = 1'b0;
  endtask

  // holds the request until rd_ready has been taken, steering rd_dready meanwhile
  task automatic run_read(input int idx);
    logic done;
    logic last_seen;
    rd_addr.flat = `STRIPE_ADDR_WIDTH'(addr_tab[idx]);
    rd_arlenw    = `STRIPE_ARLENW_WIDTH'(len_tab[idx]);
    rd_valid     = 1'b1;
    done         = 1'b0;
    last_seen    = 1'b0;
    while (!done) begin
      if (bp_tab[idx]) begin
        rng       = xorshift32(rng);
        rd_dready = rng[0];
      end else begin
        rd_dready = 1'b1;
      end
      if (rd_dvalid && rd_dready && rd_last) begin
        last_seen = 1'b1;
        if (rd_resp !== resp_tab[idx]) begin
          table_errors++;
          $display("Error at %t: rd_resp on the final beat of entry %0d expected %0d, got %0d",
                   $realtime, idx, resp_tab[idx], rd_resp);
        end
      end
      if (rd_ready) begin
        done = 1'b1;
      end
      @(negedge axi_clk);
    end
    if (!last_seen) begin
      table_errors++;
      $display("Entry %0d finished without a beat carrying rd_last", idx);
    end
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    axi_resetn   = 1'b0;
    rd_addr      = '0;
    rd_arlenw    = '0;
    rd_valid     = 1'b0;
    rd_dready    = 1'b0;
    wr_en        = 1'b0;
    wr_addr      = '0;
    wr_data      = '0;
    report_req   = 1'b0;
    table_errors = 0;
    rng          = 32'h349a1820;
    build_table();
    repeat (RESET_CYCLES) @(negedge axi_clk);
    axi_resetn = 1'b1;
    repeat (2) @(negedge axi_clk);
    for (int i = 0; i < n_entries; i++) begin
      if (op_tab[i] == OP_FILL) begin
        fill_banks();
      end else begin
        run_read(i);
        // a chained entry keeps rd_valid high into the next request
        if (!chain_tab[i]) begin
          // one idle cycle separates unchained requests
          rd_valid  = 1'b0;
          rd_dready = 1'b0;
          @(negedge axi_clk);
        end
      end
    end
    repeat (4) @(negedge axi_clk);
    report_req = 1'b1;
    wait (report_done);
    if (error_total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // allows every entry its longest burst several times over, plus reset and the fill
  initial begin
    int limit;
    @(posedge axi_clk);
    limit = RESET_CYCLES + FILL_WORDS + n_entries * (max_arlenw() + 8) * 4;
    repeat (limit) @(posedge axi_clk);
    $display("Timeout: the test did not finish within %0d clock cycles", limit);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* sim/stripe_checker.sv */
`timescale 1ns/1ps
`include "stripe_defines.svh"

// Reference model for the striped memory. It mirrors the host write port and
// checks every host read beat against the words that the model holds
module stripe_checker import stripe_addr_pkg::*; (
  input  logic                            axi_clk,
  input  logic                            axi_resetn,
  input  word_addr_t                      rd_addr,
  input  logic [`STRIPE_ARLENW_WIDTH-1:0] rd_arlenw,
  input  logic                            rd_valid,
  input  logic                            rd_ready,
  input  rd_word_t                        rd_data,
  input  rd_resp_t                        rd_resp,
  input  logic                            rd_dvalid,
  input  logic                            rd_last,
  input  logic                            rd_dready,
  input  logic                            wr_en,
  input  word_addr_t                      wr_addr,
  input  rd_word_t                        wr_data,
  input  int                              tb_errors,
  input  logic                            report_req,
  output logic                            report_done,
  output int                              error_total
);

  localparam int NUM_S = `STRIPE_NUM_S;
  localparam int MEM_WORDS = 1 << `STRIPE_ADDR_WIDTH;

  rd_word_t model [MEM_WORDS];

  logic     active;
  int       req_start;
  int       req_beats;
  int       beat_cnt;
  int       reset_edges;
  int       requests_done;
  logic     stalled;
  rd_word_t stall_data;
  rd_resp_t stall_resp;
  logic     stall_last;
  int       data_errors;
  int       resp_errors;
  int       last_errors;
  int       proto_errors;

  initial begin
    active        = 1'b0;
    stalled       = 1'b0;
    reset_edges   = 0;
    requests_done = 0;
    data_errors   = 0;
    resp_errors   = 0;
    last_errors   = 0;
    proto_errors  = 0;
    report_done   = 1'b0;
  end

  assign error_total = data_errors + resp_errors + last_errors + proto_errors + tb_errors;

  always @(posedge axi_clk) begin
    if (wr_en) begin
      model[wr_addr.flat] <= wr_data;
    end
  end

  // word k of a request is the flat word start+k, zero with SLVERR past the bank depth
  task automatic check_beat();
    int       a;
    rd_word_t exp_data;
    rd_resp_t exp_resp;
    logic     exp_last;
    a = (req_start + beat_cnt) % MEM_WORDS;
    if (a / NUM_S >= `STRIPE_BANK_DEPTH) begin
      exp_data = '0;
      exp_resp = SLVERR;
    end else begin
      exp_data = model[a];
      exp_resp = OKAY;
    end
    exp_last = beat_cnt == req_beats - 1;
    if (beat_cnt >= req_beats) begin
      proto_errors++;
      $display("An extra beat arrived at %t after all %0d words of the request at %0d",
               $realtime, req_beats, req_start);
    end else begin
      if (rd_data !== exp_data) begin
        data_errors++;
        $display("Error at %t: rd_data of word %0d expected %h, got %h",
                 $realtime, a, exp_data, rd_data);
      end
      if (rd_resp !== exp_resp) begin
        resp_errors++;
        $display("Error at %t: rd_resp of word %0d expected %0d, got %0d",
                 $realtime, a, exp_resp, rd_resp);
      end
      if (rd_last !== exp_last) begin
        last_errors++;
        $display("Error at %t: rd_last of word %0d expected %b, got %b",
                 $realtime, a, exp_last, rd_last);
      end
    end
    beat_cnt++;
  endtask

  always @(posedge axi_clk) begin
    if (!axi_resetn) begin
      // the first edge is the one that clears the FSMs
      if (reset_edges > 0 && (rd_ready !== 1'b0 || rd_dvalid !== 1'b0 || rd_last !== 1'b0)) begin
        proto_errors++;
        $display("Read outputs were not low during reset at %t", $realtime);
      end
      reset_edges++;
      active  = 1'b0;
      stalled = 1'b0;
    end else begin
      if (stalled && (rd_dvalid !== 1'b1 || rd_data !== stall_data
                      || rd_resp !== stall_resp || rd_last !== stall_last)) begin
        proto_errors++;
        $display("The held beat changed while rd_dready was low at %t", $realtime);
      end
      stalled    = rd_dvalid && !rd_dready;
      stall_data = rd_data;
      stall_resp = rd_resp;
      stall_last = rd_last;
      if (!active) begin
        if (rd_ready !== 1'b0 || rd_dvalid !== 1'b0 || rd_last !== 1'b0) begin
          proto_errors++;
          $display("Read outputs were active with no request at %t", $realtime);
        end
        // the stripe reader takes a request on the first edge it sees rd_valid
        if (rd_valid) begin
          active    = 1'b1;
          req_start = int'(rd_addr.flat);
          req_beats = int'(rd_arlenw) + 1;
          beat_cnt  = 0;
        end
      end else begin
        if (rd_dvalid && rd_dready) begin
          check_beat();
        end
        if (rd_valid && rd_ready) begin
          if (beat_cnt != req_beats) begin
            proto_errors++;
            $display("The request at %0d ended after %0d beats instead of %0d at %t",
                     req_start, beat_cnt, req_beats, $realtime);
          end
          active = 1'b0;
          requests_done++;
        end
      end
    end
  end

  always @(posedge report_req) begin
    $display("Checked %0d requests: %0d data, %0d response, %0d last, %0d protocol, %0d table errors",
             requests_done, data_errors, resp_errors, last_errors, proto_errors, tb_errors);
    report_done = 1'b1;
  end

endmodule

/* source/stripe_top.sv */
`timescale 1ns/1ps
`include "stripe_defines.svh"

// Striped word memory: the host reads through the stripe reader, and
// writes go straight to every bank, which keeps its own words
module stripe_top import stripe_addr_pkg::*; (
  input  logic                            axi_clk,
  input  logic                            axi_resetn,

  input  word_addr_t                      rd_addr,
  input  logic [`STRIPE_ARLENW_WIDTH-1:0] rd_arlenw,
  input  logic                            rd_valid,
  output logic                            rd_ready,
  output rd_word_t                        rd_data,
  output rd_resp_t                        rd_resp,
  output logic                            rd_dvalid,
  output logic                            rd_last,
  input  logic                            rd_dready,

  input  logic                            wr_en,
  input  word_addr_t                      wr_addr,
  input  rd_word_t                        wr_data
);

  // one read link per bank
  word_rd_if bank_link [`STRIPE_NUM_S] ();

  stripe_reader stripe_reader_inst (
    .axi_clk   (axi_clk),
    .axi_resetn(axi_resetn),
    .rd_addr   (rd_addr),
    .rd_arlenw (rd_arlenw),
    .rd_valid  (rd_valid),
    .rd_ready  (rd_ready),
    .rd_data   (rd_data),
    .rd_resp   (rd_resp),
    .rd_dvalid (rd_dvalid),
    .rd_last   (rd_last),
    .rd_dready (rd_dready),
    .bank      (bank_link)
  );

  for (genvar i = 0; i < `STRIPE_NUM_S; i++) begin : gen_bank
    bank_ram #(
      .BANK_INDEX(i)
    ) bank_ram_inst (
      .axi_clk   (axi_clk),
      .axi_resetn(axi_resetn),
      .wr_en     (wr_en),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data),
      .rd        (bank_link[i])
    );
  end

endmodule

/* stripe_reader/stripe_reader.sv */
`timescale 1ns/1ps
`include "stripe_defines.svh"

// Splits a host read across one word reader per bank. Each lane prefetches
// its own words, and the beats go back to the host in flat-address order.
// The start address and arlenw+1 must both be multiples of the bank count.
module stripe_reader import stripe_addr_pkg::*; import stripe_ctrl_pkg::*; (
  input  logic                            axi_clk,
  input  logic                            axi_resetn,

  input  word_addr_t                      rd_addr,
  input  logic [`STRIPE_ARLENW_WIDTH-1:0] rd_arlenw,
  input  logic                            rd_valid,
  output logic                            rd_ready,
  output rd_word_t                        rd_data,
  output rd_resp_t                        rd_resp,
  output logic                            rd_dvalid,
  output logic                            rd_last,
  input  logic                            rd_dready,

  word_rd_if.requester                    bank [`STRIPE_NUM_S]
);

  localparam int NUM_S = `STRIPE_NUM_S;
  localparam int IDX_BITS = (NUM_S > 1) ? $clog2(NUM_S) : 1;

  stripe_state_t state;
  stripe_state_t next_state;
  logic          burst_start;
  logic          host_beat;

  logic [`STRIPE_ARLENW_WIDTH:0] host_words;

  word_addr_t                      lane_addr   [NUM_S];
  logic [`STRIPE_ARLENW_WIDTH-1:0] lane_arlenw [NUM_S];
  logic                            lane_valid  [NUM_S];
  logic                            lane_ready  [NUM_S];
  rd_word_t                        lane_data   [NUM_S];
  rd_resp_t                        lane_resp   [NUM_S];
  logic                            lane_bvalid [NUM_S];
  logic                            lane_last   [NUM_S];
  logic                            lane_bready [NUM_S];

  logic [IDX_BITS-1:0] lane_idx;
  logic                lane_idx_last;

  for (genvar i = 0; i < NUM_S; i++) begin : gen_lane
    read_words #(
      .STRIDE(NUM_S)
    ) read_words_inst (
      .axi_clk   (axi_clk),
      .axi_resetn(axi_resetn),
      .req_addr  (lane_addr[i]),
      .req_arlenw(lane_arlenw[i]),
      .req_valid (lane_valid[i]),
      .req_ready (lane_ready[i]),
      .beat_data (lane_data[i]),
      .beat_resp (lane_resp[i]),
      .beat_valid(lane_bvalid[i]),
      .beat_last (lane_last[i]),
      .beat_ready(lane_bready[i]),
      .bank      (bank[i])
    );
  end

  // one extra bit so a full-range count plus one does not wrap
  assign host_words = {1'b0, rd_arlenw} + 1'b1;

  assign host_beat     = rd_dvalid && rd_dready;
  assign lane_idx_last = lane_idx == IDX_BITS'(NUM_S - 1);

  always_comb begin
    next_state  = state;
    burst_start = 1'b0;
    case (state)
      ST_IDLE: begin
        if (rd_valid) begin
          next_state  = ST_INIT_BURST;
          burst_start = 1'b1;
        end
      end
      ST_INIT_BURST: begin
        next_state = ST_READING_BEATS;
      end
      ST_READING_BEATS: begin
        if (host_beat && rd_last) begin
          next_state = ST_COMPLETE;
        end
      end
      default: begin
        next_state = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      state    <= ST_IDLE;
      lane_idx <= '0;
    end else begin
      state <= next_state;
      if (burst_start || (host_beat && lane_idx_last)) begin
        lane_idx <= '0;
      end else if (host_beat) begin
        lane_idx <= lane_idx + 1'b1;
      end
    end
  end

  // each lane starts at its own bank and reads every NUM_S-th word
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      for (int i = 0; i < NUM_S; i++) begin
        lane_valid[i] <= 1'b0;
      end
    end else begin
      for (int i = 0; i < NUM_S; i++) begin
        if (burst_start) begin
          lane_valid[i] <= 1'b1;
        end else if (lane_ready[i]) begin
          lane_valid[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (burst_start) begin
      for (int i = 0; i < NUM_S; i++) begin
        lane_addr[i].flat <= rd_addr.flat + `STRIPE_ADDR_WIDTH'(i);
        lane_arlenw[i]    <= `STRIPE_ARLENW_WIDTH'(host_words / NUM_S - 1);
      end
    end
  end

  // only the selected lane sees the host and its ready
  always_comb begin
    rd_dvalid = 1'b0;
    rd_data   = lane_data[lane_idx];
    rd_resp   = lane_resp[lane_idx];
    for (int i = 0; i < NUM_S; i++) begin
      lane_bready[i] = 1'b0;
    end
    if (state == ST_READING_BEATS) begin
      rd_dvalid             = lane_bvalid[lane_idx];
      lane_bready[lane_idx] = rd_dready;
    end
  end

  assign rd_last  = rd_dvalid && lane_idx_last && lane_last[NUM_S-1];
  assign rd_ready = state == ST_COMPLETE;

endmodule

/* stripe_reader/read_words.sv */
`timescale 1ns/1ps
`include "stripe_defines.svh"

// Reads req_arlenw+1 words from one bank, STRIDE flat addresses apart.
// One address is outstanding at a time and each bank beat is passed on
// as it is, so the bank itself holds the prefetched word.
module read_words import stripe_addr_pkg::*; import stripe_ctrl_pkg::*; #(
  parameter int STRIDE = 2
) (
  input  logic                            axi_clk,
  input  logic                            axi_resetn,

  input  word_addr_t                      req_addr,
  input  logic [`STRIPE_ARLENW_WIDTH-1:0] req_arlenw,
  input  logic                            req_valid,
  output logic                            req_ready,

  output rd_word_t                        beat_data,
  output rd_resp_t                        beat_resp,
  output logic                            beat_valid,
  output logic                            beat_last,
  input  logic                            beat_ready,

  word_rd_if.requester                    bank
);

  words_state_t state;

  word_addr_t                      addr_q;
  logic [`STRIPE_ARLENW_WIDTH-1:0] remain;
  logic                            beat_done;

  assign beat_done = beat_valid && beat_ready;

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      state <= RW_IDLE;
    end else begin
      case (state)
        RW_IDLE: begin
          if (req_valid) begin
            state <= RW_ISSUE;
          end
        end
        RW_ISSUE: begin
          if (bank.arready) begin
            state <= RW_WAIT_DATA;
          end
        end
        RW_WAIT_DATA: begin
          if (beat_done) begin
            state <= (remain == '0) ? RW_IDLE : RW_ISSUE;
          end
        end
        default: begin
          state <= RW_IDLE;
        end
      endcase
    end
  end

  // address and count only matter outside idle
  always_ff @(posedge axi_clk) begin
    if (state == RW_IDLE && req_valid) begin
      addr_q <= req_addr;
      remain <= req_arlenw;
    end else if (state == RW_WAIT_DATA && beat_done) begin
      addr_q.flat <= addr_q.flat + `STRIPE_ADDR_WIDTH'(STRIDE);
      remain      <= remain - 1'b1;
    end
  end

  assign req_ready    = state == RW_IDLE;
  assign bank.araddr  = addr_q;
  assign bank.arvalid = state == RW_ISSUE;
  assign bank.rready  = (state == RW_WAIT_DATA) && beat_ready;

  assign beat_valid = (state == RW_WAIT_DATA) && bank.rvalid;
  assign beat_data  = bank.rdata;
  assign beat_resp  = bank.rresp;
  // the count runs down to zero on the final word of this lane
  assign beat_last  = (state == RW_WAIT_DATA) && (remain == '0);

endmodule

/* source/bank_ram.sv */
`timescale 1ns/1ps
`include "stripe_defines.svh"

// One bank of the striped memory. Writes come from the shared host write
// port and are kept only when the bank select matches. Reads return one
// word a cycle after the address is taken.
module bank_ram import stripe_addr_pkg::*; #(
  parameter int BANK_INDEX = 0
) (
  input  logic         axi_clk,
  input  logic         axi_resetn,

  input  logic         wr_en,
  input  word_addr_t   wr_addr,
  input  rd_word_t     wr_data,

  word_rd_if.responder rd
);

  localparam int DEPTH_BITS = $clog2(`STRIPE_BANK_DEPTH);

  rd_word_t mem [`STRIPE_BANK_DEPTH];

  logic wr_hit;
  logic rd_take;
  logic rd_in_range;

  assign wr_hit = wr_en
               && (wr_addr.split.bank == `STRIPE_SEL_WIDTH'(BANK_INDEX))
               && (int'(wr_addr.split.offset) < `STRIPE_BANK_DEPTH);

  always_ff @(posedge axi_clk) begin
    if (wr_hit) begin
      mem[wr_addr.split.offset[DEPTH_BITS-1:0]] <= wr_data;
    end
  end

  // a new address is taken only once the previous beat has left
  assign rd.arready  = !rd.rvalid;
  assign rd_take     = rd.arvalid && rd.arready;
  assign rd_in_range = int'(rd.araddr.split.offset) < `STRIPE_BANK_DEPTH;

  // a write to the same word in this cycle is not seen here
  always_ff @(posedge axi_clk) begin
    if (rd_take) begin
      if (rd_in_range) begin
        rd.rdata <= mem[rd.araddr.split.offset[DEPTH_BITS-1:0]];
        rd.rresp <= OKAY;
      end else begin
        rd.rdata <= '0;
        rd.rresp <= SLVERR;
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      rd.rvalid <= 1'b0;
    end else if (rd_take) begin
      rd.rvalid <= 1'b1;
    end else if (rd.rready) begin
      rd.rvalid <= 1'b0;
    end
  end

endmodule

/* common/word_rd_if.sv */
`timescale 1ns/1ps

// single-word read channel with separate address and data handshakes
interface word_rd_if import stripe_addr_pkg::*; ();

  word_addr_t araddr;
  logic       arvalid;
  logic       arready;
  rd_word_t   rdata;
  rd_resp_t   rresp;
  logic       rvalid;
  logic       rready;

  modport requester(
    output araddr,
    output arvalid,
    input  arready,
    input  rdata,
    input  rresp,
    input  rvalid,
    output rready
  );

  modport responder(
    input  araddr,
    input  arvalid,
    output arready,
    output rdata,
    output rresp,
    output rvalid,
    input  rready
  );

endinterface

/* common/stripe_ctrl_pkg.sv */
package stripe_ctrl_pkg;

  // stripe reader FSM
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_INIT_BURST,
    ST_READING_BEATS,
    ST_COMPLETE
  } stripe_state_t;

  // per-lane word reader FSM
  typedef enum logic [1:0] {
    RW_IDLE,
    RW_ISSUE,
    RW_WAIT_DATA
  } words_state_t;

endpackage

/* common/stripe_addr_pkg.sv */
`include "stripe_defines.svh"

package stripe_addr_pkg;

  typedef logic [`STRIPE_DATA_WIDTH-1:0] rd_word_t;

  // same encoding as the AXI read response
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } rd_resp_t;

  // bank view of a word address, the low bits pick the bank
  typedef struct packed {
    logic [`STRIPE_ADDR_WIDTH-`STRIPE_SEL_WIDTH-1:0] offset;
    logic [`STRIPE_SEL_WIDTH-1:0]                    bank;
  } bank_addr_t;

  // the flat view is used by the readers, the split view by the banks
  typedef union packed {
    logic [`STRIPE_ADDR_WIDTH-1:0] flat;
    bank_addr_t                    split;
  } word_addr_t;

endpackage

/* common/stripe_defines.svh */
`ifndef STRIPE_DEFINES_SVH
`define STRIPE_DEFINES_SVH

// number of bank memories the words are striped across
`define STRIPE_NUM_S 2

// bits of the flat word address that select the bank
`define STRIPE_SEL_WIDTH 1

// flat word address, word and zero-based word count widths
`define STRIPE_ADDR_WIDTH 10
`define STRIPE_DATA_WIDTH 16
`define STRIPE_ARLENW_WIDTH 8

// words held by each bank, higher offsets answer with a slave error
`define STRIPE_BANK_DEPTH 256

`endif
